//--- include/ecc_params.svh
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// ----------------------------------------------------------------------
// sizes of the 115/8 single-correct, double-detect code
// ----------------------------------------------------------------------

`define ECC_DATA_WIDTH   115 // data bits per word.
`define ECC_PARITY_WIDTH 8   // check bits per word.

// one syndrome column per data bit.
`define ECC_COLUMNS      `ECC_DATA_WIDTH

`endif

//--- logic/ecc_code_pkg.sv
package ecc_code_pkg;

`include "ecc_params.svh"

    typedef logic [`ECC_DATA_WIDTH-1:0]   data_word_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] check_word_t; // check word or syndrome.

    // ----------------------------------------------------------------------
    // syndrome column of each data bit, entry 0 first
    // ----------------------------------------------------------------------
    // all columns have odd weight of three or more, so a double error
    // always leaves an even-weight nonzero syndrome.
    localparam check_word_t SYNDROME_COLUMNS [`ECC_COLUMNS] = '{
        8'b1000_0011, // bit 0.
        8'b1000_0101,
        8'b1000_0110,
        8'b0000_0111,
        8'b1000_1001,
        8'b1000_1010,
        8'b0000_1011,
        8'b1000_1100,
        8'b0000_1101,
        8'b0000_1110,
        8'b1000_1111, // bit 10.
        8'b1001_0001,
        8'b1001_0010,
        8'b0001_0011,
        8'b1001_0100,
        8'b0001_0101,
        8'b0001_0110,
        8'b1001_0111,
        8'b1001_1000,
        8'b0001_1001,
        8'b0001_1010, // bit 20.
        8'b1001_1011,
        8'b0001_1100,
        8'b1001_1101,
        8'b1001_1110,
        8'b0001_1111,
        8'b1010_0001,
        8'b1010_0010,
        8'b0010_0011,
        8'b1010_0100,
        8'b0010_0101, // bit 30.
        8'b0010_0110,
        8'b1010_0111,
        8'b1010_1000,
        8'b0010_1001,
        8'b0010_1010,
        8'b1010_1011,
        8'b0010_1100,
        8'b1010_1101,
        8'b1010_1110,
        8'b0010_1111, // bit 40.
        8'b1011_0000,
        8'b0011_0001,
        8'b0011_0010,
        8'b1011_0011,
        8'b0011_0100,
        8'b1011_0101,
        8'b1011_0110,
        8'b0011_0111,
        8'b0011_1000,
        8'b1011_1001, // bit 50.
        8'b1011_1010,
        8'b0011_1011,
        8'b1011_1100,
        8'b0011_1101,
        8'b0011_1110,
        8'b1011_1111,
        8'b1100_0001,
        8'b1100_0010,
        8'b0100_0011,
        8'b1100_0100, // bit 60.
        8'b0100_0101,
        8'b0100_0110,
        8'b1100_0111,
        8'b1100_1000,
        8'b0100_1001,
        8'b0100_1010,
        8'b1100_1011,
        8'b0100_1100,
        8'b1100_1101,
        8'b1100_1110, // bit 70.
        8'b0100_1111,
        8'b1101_0000,
        8'b0101_0001,
        8'b0101_0010,
        8'b1101_0011,
        8'b0101_0100,
        8'b1101_0101,
        8'b1101_0110,
        8'b0101_0111,
        8'b0101_1000, // bit 80.
        8'b1101_1001,
        8'b1101_1010,
        8'b0101_1011,
        8'b1101_1100,
        8'b0101_1101,
        8'b0101_1110,
        8'b1101_1111,
        8'b1110_0000,
        8'b0110_0001,
        8'b0110_0010, // bit 90.
        8'b1110_0011,
        8'b0110_0100,
        8'b1110_0101,
        8'b1110_0110,
        8'b0110_0111,
        8'b0110_1000,
        8'b1110_1001,
        8'b1110_1010,
        8'b0110_1011,
        8'b1110_1100, // bit 100.
        8'b0110_1101,
        8'b0110_1110,
        8'b1110_1111,
        8'b0111_0000,
        8'b1111_0001,
        8'b1111_0010,
        8'b0111_0011,
        8'b1111_0100,
        8'b0111_0101,
        8'b0111_0110, // bit 110.
        8'b1111_0111,
        8'b1111_1000,
        8'b0111_1001,
        8'b0111_1010  // bit 114.
    };

endpackage

//--- logic/ecc_status_pkg.sv
package ecc_status_pkg;

`include "ecc_params.svh"

    // ----------------------------------------------------------------------
    // outcome of one syndrome check
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        ECC_CLEAN  = 2'b00, // syndrome zero.
        ECC_SINGLE = 2'b01, // one data or check bit flipped.
        ECC_DOUBLE = 2'b10  // uncorrectable.
    } ecc_kind_e;

    // decoder to check stage only.
    typedef struct packed {
        ecc_kind_e                kind;
        ecc_code_pkg::data_word_t mask; // one-hot on a data-bit error.
    } check_result_t;

endpackage

//--- logic/ecc_encoder.sv
`timescale 1ns/1ns

`include "ecc_params.svh"

module ecc_encoder (
    input  ecc_code_pkg::data_word_t  data,
    output ecc_code_pkg::check_word_t parity
);

    // gathers the data bits that feed check bit row.
    function automatic ecc_code_pkg::data_word_t row_select(input int row);
        ecc_code_pkg::data_word_t sel;
        sel = '0;
        for (int i = 0; i < `ECC_COLUMNS; i++) begin
            sel[i] = ecc_code_pkg::SYNDROME_COLUMNS[i][row];
        end
        return sel;
    endfunction

    // ----------------------------------------------------------------------
    // one xor tree per check bit
    // ----------------------------------------------------------------------
    generate
        for (genvar j = 0; j < `ECC_PARITY_WIDTH; j++) begin : g_row
            localparam ecc_code_pkg::data_word_t ROW_SEL = row_select(j);

            assign parity[j] = ^(data & ROW_SEL); // constant mask, folds to a plain tree.
        end
    endgenerate

endmodule

//--- logic/ecc_syndrome_decoder.sv
`timescale 1ns/1ns

`include "ecc_params.svh"

module ecc_syndrome_decoder (
    input  ecc_code_pkg::check_word_t     syndrome,
    output ecc_status_pkg::check_result_t result
);

    ecc_code_pkg::data_word_t  col_hit;   // syndrome matches column i.
    ecc_code_pkg::check_word_t low_clear; // syndrome with lowest set bit removed.
    logic                      is_zero;
    logic                      is_column;
    logic                      is_weight_one;

    // ----------------------------------------------------------------------
    // column match, one comparator per data bit
    // ----------------------------------------------------------------------
    generate
        for (genvar i = 0; i < `ECC_COLUMNS; i++) begin : g_col
            assign col_hit[i] = (syndrome == ecc_code_pkg::SYNDROME_COLUMNS[i]);
        end
    endgenerate

    assign is_zero   = (syndrome == '0);
    assign is_column = |col_hit; // columns are distinct, so at most one hit.

    // a single set bit means one check bit flipped.
    assign low_clear     = syndrome & (syndrome - 1'b1);
    assign is_weight_one = !is_zero && (low_clear == '0);

    // ----------------------------------------------------------------------
    // classification
    // ----------------------------------------------------------------------
    always_comb begin
        result.mask = '0;
        result.kind = ecc_status_pkg::ECC_DOUBLE; // anything unlisted.
        if (is_zero) begin
            result.kind = ecc_status_pkg::ECC_CLEAN;
        end else if (is_column) begin
            result.kind = ecc_status_pkg::ECC_SINGLE;
            result.mask = col_hit;
        end else if (is_weight_one) begin
            result.kind = ecc_status_pkg::ECC_SINGLE; // data stays as is.
        end
    end

endmodule

//--- logic/ecc_check_ctrl.sv
`timescale 1ns/1ns

module ecc_check_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic                          bypass,
    input  ecc_code_pkg::data_word_t      data,
    input  ecc_code_pkg::check_word_t     parity,
    input  ecc_status_pkg::check_result_t result,
    output logic                          out_valid,
    output logic                          sbit_err,
    output logic                          dbit_err,
    output ecc_code_pkg::data_word_t      data_out,
    output ecc_code_pkg::check_word_t     parity_out
);

    ecc_code_pkg::data_word_t data_next;
    logic                     sbit_next;
    logic                     dbit_next;

    // ----------------------------------------------------------------------
    // correction and flag decode
    // ----------------------------------------------------------------------
    assign data_next = bypass ? data : (data ^ result.mask);

    always_comb begin
        sbit_next = 1'b0;
        dbit_next = 1'b0;
        if (!bypass) begin
            case (result.kind)
                ecc_status_pkg::ECC_SINGLE: sbit_next = 1'b1;
                ecc_status_pkg::ECC_DOUBLE: dbit_next = 1'b1;
                default: ;                               // clean word.
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // output register stage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
        end else begin
            out_valid <= in_valid;
            sbit_err  <= in_valid & sbit_next; // flags drop with the strobe.
            dbit_err  <= in_valid & dbit_next;
        end
    end

    // payload holds its last value between strobes.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            data_out   <= data_next;
            parity_out <= parity; // regenerated word of the raw data.
        end
    end

endmodule

//--- logic/ecc_115_cal.sv
`timescale 1ns/1ns

module ecc_115_cal (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  ecc_code_pkg::data_word_t  data_in,
    input  ecc_code_pkg::check_word_t parity_in,
    input  logic                      bypass,
    output logic                      out_valid,
    output ecc_code_pkg::data_word_t  data_out,
    output ecc_code_pkg::check_word_t parity_out,
    output logic                      sbit_err,
    output logic                      dbit_err
);

    ecc_code_pkg::check_word_t     regen_parity;
    ecc_code_pkg::check_word_t     syndrome;
    ecc_status_pkg::check_result_t result;

    ecc_encoder ecc_encoder_inst (
        .data   (data_in),
        .parity (regen_parity)
    );

    assign syndrome = parity_in ^ regen_parity; // stored against regenerated.

    ecc_syndrome_decoder ecc_syndrome_decoder_inst (
        .syndrome (syndrome),
        .result   (result)
    );

    ecc_check_ctrl ecc_check_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .bypass     (bypass),
        .data       (data_in),
        .parity     (regen_parity),
        .result     (result),
        .out_valid  (out_valid),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .data_out   (data_out),
        .parity_out (parity_out)
    );

endmodule

//--- tests/ecc_115_cal_tb.sv
`timescale 1ns/1ns

`include "ecc_params.svh"

module ecc_115_cal_tb;

    localparam int NUM_ROWS    = 16;
    localparam int CYCLE_LIMIT = 2 * NUM_ROWS + 32; // two passes plus reset and idle.

    typedef struct packed {
        int                        flip_a;  // flipped data bit or -1.
        int                        flip_b;
        int                        chk_a;   // flipped check bit or -1.
        int                        chk_b;
        logic                      byp;
        ecc_status_pkg::ecc_kind_e kind;
    } row_t;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    ecc_code_pkg::data_word_t  data_in;
    ecc_code_pkg::check_word_t parity_in;
    logic                      bypass;
    logic                      out_valid;
    ecc_code_pkg::data_word_t  data_out;
    ecc_code_pkg::check_word_t parity_out;
    logic                      sbit_err;
    logic                      dbit_err;

    row_t                      rows [NUM_ROWS];
    ecc_code_pkg::data_word_t  row_data [NUM_ROWS];
    ecc_code_pkg::check_word_t good_word [NUM_ROWS]; // measured in pass one.
    int                        error_count = 0;
    int                        cycle_count = 0;

    ecc_115_cal ecc_115_cal_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ----------------------------------------------------------------------
    // reference code and table helpers
    // ----------------------------------------------------------------------
    // every set data bit adds its own column into the check word.
    function automatic ecc_code_pkg::check_word_t ref_check_word(
        input ecc_code_pkg::data_word_t d
    );
        ecc_code_pkg::check_word_t c;
        c = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) c = c ^ ecc_code_pkg::SYNDROME_COLUMNS[i];
        end
        return c;
    endfunction

    function automatic ecc_code_pkg::data_word_t random_word();
        logic [127:0] w;
        w = {$urandom, $urandom, $urandom, $urandom};
        return w[`ECC_DATA_WIDTH-1:0];
    endfunction

    task automatic set_row(input int idx, input int fa, input int fb, input int ca,
                           input int cb, input logic byp,
                           input ecc_status_pkg::ecc_kind_e kind);
        rows[idx].flip_a = fa;
        rows[idx].flip_b = fb;
        rows[idx].chk_a  = ca;
        rows[idx].chk_b  = cb;
        rows[idx].byp    = byp;
        rows[idx].kind   = kind;
    endtask

    task automatic build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_data[i] = random_word();
        end
        row_data[0] = '0;                        // zero word.
        row_data[3] = row_data[1] ^ row_data[2]; // linearity row.
        set_row(0,  -1,  -1, -1, -1, 1'b0, ecc_status_pkg::ECC_CLEAN);
        set_row(1,  -1,  -1, -1, -1, 1'b0, ecc_status_pkg::ECC_CLEAN);
        set_row(2,  -1,  -1, -1, -1, 1'b0, ecc_status_pkg::ECC_CLEAN);
        set_row(3,  -1,  -1, -1, -1, 1'b0, ecc_status_pkg::ECC_CLEAN);
        set_row(4,   0,  -1, -1, -1, 1'b0, ecc_status_pkg::ECC_SINGLE);
        set_row(5,  57,  -1, -1, -1, 1'b0, ecc_status_pkg::ECC_SINGLE);
        set_row(6, 114,  -1, -1, -1, 1'b0, ecc_status_pkg::ECC_SINGLE);
        set_row(7,  -1,  -1,  0, -1, 1'b0, ecc_status_pkg::ECC_SINGLE);
        set_row(8,  -1,  -1,  7, -1, 1'b0, ecc_status_pkg::ECC_SINGLE);
        set_row(9,   3,  90, -1, -1, 1'b0, ecc_status_pkg::ECC_DOUBLE);
        set_row(10, -1,  -1,  2,  5, 1'b0, ecc_status_pkg::ECC_DOUBLE);
        set_row(11, 40,  -1,  1, -1, 1'b0, ecc_status_pkg::ECC_DOUBLE);
        set_row(12, 20,  -1, -1, -1, 1'b1, ecc_status_pkg::ECC_SINGLE);
        set_row(13, -1,  -1,  0,  3, 1'b1, ecc_status_pkg::ECC_DOUBLE);
        set_row(14, -1,  -1, -1, -1, 1'b1, ecc_status_pkg::ECC_CLEAN);
        set_row(15,  1, 114, -1, -1, 1'b0, ecc_status_pkg::ECC_DOUBLE);
    endtask

    function automatic ecc_code_pkg::data_word_t flipped_data(input int idx);
        ecc_code_pkg::data_word_t w;
        w = row_data[idx];
        if (rows[idx].flip_a >= 0) w[rows[idx].flip_a] = ~w[rows[idx].flip_a];
        if (rows[idx].flip_b >= 0) w[rows[idx].flip_b] = ~w[rows[idx].flip_b];
        return w;
    endfunction

    function automatic ecc_code_pkg::check_word_t flipped_check(input int idx);
        ecc_code_pkg::check_word_t c;
        c = good_word[idx];
        if (rows[idx].chk_a >= 0) c[rows[idx].chk_a] = ~c[rows[idx].chk_a];
        if (rows[idx].chk_b >= 0) c[rows[idx].chk_b] = ~c[rows[idx].chk_b];
        return c;
    endfunction

    task automatic compare_value(input logic [127:0] got, input logic [127:0] expected,
                                 input string what);
        if (got !== expected) begin
            error_count++;
            $display("ERR %0t ns: %s mismatch, got %h expected %h", $time, what, got,
                     expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // ----------------------------------------------------------------------
    // drive and check one row
    // ----------------------------------------------------------------------
    task automatic check_clean(input int idx);
        compare_value(out_valid, 1'b1, $sformatf("pass one row %0d out_valid", idx));
        good_word[idx] = parity_out;
    endtask

    task automatic check_row(input int idx);
        ecc_code_pkg::data_word_t  exp_data;
        ecc_code_pkg::check_word_t exp_parity;
        logic                      exp_sbit;
        logic                      exp_dbit;
        exp_data = flipped_data(idx);
        if (!rows[idx].byp && rows[idx].kind == ecc_status_pkg::ECC_SINGLE &&
            rows[idx].flip_a >= 0) begin
            exp_data = row_data[idx]; // single data error is corrected.
        end
        if (rows[idx].flip_a < 0) exp_parity = good_word[idx];
        else exp_parity = ref_check_word(flipped_data(idx));
        exp_sbit = !rows[idx].byp && (rows[idx].kind == ecc_status_pkg::ECC_SINGLE);
        exp_dbit = !rows[idx].byp && (rows[idx].kind == ecc_status_pkg::ECC_DOUBLE);
        compare_value(out_valid, 1'b1, $sformatf("row %0d out_valid", idx));
        compare_value(data_out, exp_data, $sformatf("row %0d data_out", idx));
        compare_value(parity_out, exp_parity, $sformatf("row %0d parity_out", idx));
        compare_value(sbit_err, exp_sbit, $sformatf("row %0d sbit_err", idx));
        compare_value(dbit_err, exp_dbit, $sformatf("row %0d dbit_err", idx));
    endtask

    task automatic check_idle(input string where);
        compare_value(out_valid, 1'b0, {where, " out_valid"});
        compare_value(sbit_err, 1'b0, {where, " sbit_err"});
        compare_value(dbit_err, 1'b0, {where, " dbit_err"});
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        void'($urandom(32'h9311_ac3a));
        build_table();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle("after reset");

        // pass one sends clean words back to back.
        for (int i = 0; i <= NUM_ROWS; i++) begin
            @(posedge clk);
            if (i < NUM_ROWS) begin
                in_valid  <= 1'b1;
                data_in   <= row_data[i];
                parity_in <= '0;
                bypass    <= 1'b0;
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) check_clean(i - 1);
        end
        @(negedge clk);
        check_idle("after pass one");
        compare_value(good_word[0], '0, "check word of zero data");
        compare_value(good_word[3], good_word[1] ^ good_word[2], "check word linearity");

        // pass two sends the flipped words.
        for (int i = 0; i <= NUM_ROWS; i++) begin
            @(posedge clk);
            if (i < NUM_ROWS) begin
                in_valid  <= 1'b1;
                data_in   <= flipped_data(i);
                parity_in <= flipped_check(i);
                bypass    <= rows[i].byp;
            end else begin
                in_valid <= 1'b0;
                bypass   <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) check_row(i - 1);
        end
        @(negedge clk);
        check_idle("after pass two");

        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- ecc_115_cal.f
+incdir+include
logic/ecc_code_pkg.sv
logic/ecc_status_pkg.sv
logic/ecc_encoder.sv
logic/ecc_syndrome_decoder.sv
logic/ecc_check_ctrl.sv
logic/ecc_115_cal.sv
tests/ecc_115_cal_tb.sv
